// File: rtl/mac_pkg.sv
// Subsystem constants, byte entry and frame length payload types
package mac_pkg;

	// ----------------------------------------
	// Port and buffer sizing
	// ----------------------------------------

	// Number of transmit lanes
	localparam int NUM_PORTS = 4;
	// Destination tag width
	localparam int PORT_BITS = 2;
	// Lane byte buffer depth, also the starting credit count
	localparam int FIFO_DEPTH = 256;
	// Credit counter holds 0 to FIFO_DEPTH inclusive
	localparam int CREDIT_BITS = 9;
	// Frame length width, up to one full buffer
	localparam int LEN_BITS = 9;
	// Statistics counter width, counters wrap
	localparam int COUNT_BITS = 16;

	// ----------------------------------------
	// Ethernet framing
	// ----------------------------------------

	// Minimum bytes before the FCS
	localparam int MIN_PAYLOAD = 60;
	localparam int PREAMBLE_BYTES = 7;
	// 96 bit times at one byte per clock
	localparam int IPG_CYCLES = 12;
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hD5;
	// Reflected CRC-32 polynomial, LSB first on the wire
	localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

	// Byte FIFO entry
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} byte_entry_t;

	// Token FIFO entry, one per buffered frame
	typedef logic [LEN_BITS-1:0] frame_len_t;

endpackage

// File: rtl/sync_fifo.sv
// Single-clock circular FIFO with type-parameterized payload
`timescale 1ns/1ps

module sync_fifo
#(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH = 16
)
(
	input  logic     clk,
	input  logic     sresetn,
	input  logic     push,
	input  payload_t wr_data,
	input  logic     pop,
	output payload_t rd_data,
	output logic     empty
);

	// Storage, no reset needed
	payload_t mem [DEPTH];

	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	// One extra bit so a full buffer is representable
	logic [$clog2(DEPTH+1)-1:0] count;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// Explicit wrap so non power of two depths also work
			if (push)
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// Show-ahead read, head entry visible the cycle after its push
	assign rd_data = mem[rd_ptr];
	assign empty   = (count == '0);

endmodule

// File: rtl/gmii_tx_mac.sv
// GMII transmit FSM with preamble, SFD, pad, CRC-32 FCS and IPG
`timescale 1ns/1ps

module gmii_tx_mac
(
	input  logic       clk,
	input  logic       sresetn,
	// A whole frame is buffered when this is high
	input  logic       frame_ready,
	input  logic [7:0] byte_data,
	input  logic       byte_last,
	output logic       byte_pop,
	output logic [7:0] eth_txd,
	output logic       eth_txen,
	output logic       eth_txer,
	output logic       frame_end
);

	typedef enum logic [2:0]
	{
		ST_WAIT,
		ST_PREAMBLE,
		ST_SFD,
		ST_DATA,
		ST_PAD,
		ST_FCS,
		ST_IPG
	} state_t;

	state_t state;
	state_t next_state;

	// Shared counter, wide enough for a full buffer of payload
	logic [mac_pkg::LEN_BITS-1:0] ctr;

	// Running CRC and its complement as sent on the wire
	logic [31:0] crc;
	logic [31:0] fcs;

	// ----------------------------------------
	// CRC-32, one byte LSB first
	// ----------------------------------------

	function automatic logic [31:0] crc_step
	(
		input logic [31:0] crc_in,
		input logic [7:0]  data
	);
		logic [31:0] c;
		c = crc_in;
		for (int i = 0; i < 8; i++)
		begin
			// Shift out one bit, fold the polynomial in on a mismatch
			if (c[0] ^ data[i])
				c = (c >> 1) ^ mac_pkg::CRC_POLY;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	assign fcs = ~crc;

	// No error injection
	assign eth_txer = 1'b0;

	// Every data cycle consumes one buffered byte
	assign byte_pop = (state == ST_DATA);

	// ----------------------------------------
	// Next state
	// ----------------------------------------

	always_comb
	begin
		next_state = state;
		case (state)
			ST_WAIT:
				if (frame_ready)
					next_state = ST_PREAMBLE;
			// Seven preamble bytes, counter starts at zero
			ST_PREAMBLE:
				if (int'(ctr) == mac_pkg::PREAMBLE_BYTES - 1)
					next_state = ST_SFD;
			ST_SFD:
				next_state = ST_DATA;
			// Last byte goes straight to FCS once the minimum is reached
			ST_DATA:
				if (byte_last)
				begin
					if (int'(ctr) >= mac_pkg::MIN_PAYLOAD - 1)
						next_state = ST_FCS;
					else
						next_state = ST_PAD;
				end
			// Counter carries on from data, so it still counts payload bytes
			ST_PAD:
				if (int'(ctr) == mac_pkg::MIN_PAYLOAD - 1)
					next_state = ST_FCS;
			ST_FCS:
				if (ctr[1:0] == 2'd3)
					next_state = ST_IPG;
			// Two more idle cycles come from wait and the output register
			ST_IPG:
				if (int'(ctr) == mac_pkg::IPG_CYCLES - 2)
					next_state = ST_WAIT;
			default:
				next_state = ST_WAIT;
		endcase
	end

	// ----------------------------------------
	// Control registers
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			state     <= ST_WAIT;
			ctr       <= '0;
			eth_txen  <= 1'b0;
			frame_end <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// Restart on state change, except data into pad
			if (next_state != state && !(state == ST_DATA && next_state == ST_PAD))
				ctr <= '0;
			else
				ctr <= ctr + 1'b1;
			// Outputs lag the state by one register
			eth_txen <= (state inside {ST_PREAMBLE, ST_SFD, ST_DATA, ST_PAD, ST_FCS});
			// First IPG cycle is when the last FCS byte is on the wire
			frame_end <= (state == ST_IPG) && (ctr == '0);
		end
	end

	// ----------------------------------------
	// Wire data and CRC
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		case (state)
			ST_PREAMBLE:
				eth_txd <= mac_pkg::PREAMBLE_BYTE;
			ST_SFD:
				eth_txd <= mac_pkg::SFD_BYTE;
			ST_DATA:
			begin
				eth_txd <= byte_data;
				crc     <= crc_step(crc, byte_data);
			end
			// Pad bytes are zero and covered by the FCS
			ST_PAD:
			begin
				eth_txd <= 8'h00;
				crc     <= crc_step(crc, 8'h00);
			end
			// Low byte of the complemented CRC first
			ST_FCS:
				eth_txd <= fcs[{ctr[1:0], 3'b000} +: 8];
			// Idle, seed the CRC for the next frame
			default:
			begin
				eth_txd <= 8'h00;
				crc     <= '1;
			end
		endcase
	end

endmodule

// File: rtl/tx_lane.sv
// Transmit lane with byte buffer, frame token buffer, MAC and completion report
`timescale 1ns/1ps

module tx_lane
(
	input  logic                clk,
	input  logic                sresetn,
	input  logic                push,
	input  logic [7:0]          push_data,
	input  logic                push_last,
	output logic                credit_return,
	output logic [7:0]          eth_txd,
	output logic                eth_txen,
	output logic                eth_txer,
	output logic                done,
	output mac_pkg::frame_len_t done_len
);

	mac_pkg::byte_entry_t byte_in;
	mac_pkg::byte_entry_t byte_out;
	logic                 byte_empty;
	logic                 byte_pop;

	mac_pkg::frame_len_t  len_count;
	mac_pkg::frame_len_t  token_in;
	mac_pkg::frame_len_t  token_out;
	logic                 token_push;
	logic                 token_pop;
	logic                 token_empty;

	// High between a frame's first and last byte leaving the buffer
	logic                 in_frame;
	logic                 frame_end;

	// ----------------------------------------
	// Write side
	// ----------------------------------------

	assign byte_in    = '{data: push_data, last: push_last};
	// Token carries the length including the byte being pushed now
	assign token_push = push && push_last;
	assign token_in   = len_count + 1'b1;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
			len_count <= '0;
		else if (push)
			len_count <= push_last ? '0 : len_count + 1'b1;
	end

	sync_fifo #(
		.payload_t (mac_pkg::byte_entry_t),
		.DEPTH     (mac_pkg::FIFO_DEPTH)
	) u_byte_fifo (
		.clk     (clk),
		.sresetn (sresetn),
		.push    (push),
		.wr_data (byte_in),
		.pop     (byte_pop),
		.rd_data (byte_out),
		.empty   (byte_empty)
	);

	// One token per complete frame
	sync_fifo #(
		.payload_t (mac_pkg::frame_len_t),
		.DEPTH     (mac_pkg::FIFO_DEPTH)
	) u_token_fifo (
		.clk     (clk),
		.sresetn (sresetn),
		.push    (token_push),
		.wr_data (token_in),
		.pop     (token_pop),
		.rd_data (token_out),
		.empty   (token_empty)
	);

	// ----------------------------------------
	// Read side
	// ----------------------------------------

	// Token is retired on the frame's first byte
	assign token_pop = byte_pop && !in_frame;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
			in_frame <= 1'b0;
		else if (byte_pop)
			in_frame <= !byte_out.last;
	end

	// Length held until the MAC finishes the FCS
	always_ff @(posedge clk)
	begin
		if (token_pop)
			done_len <= token_out;
	end

	gmii_tx_mac u_mac (
		.clk         (clk),
		.sresetn     (sresetn),
		.frame_ready (!token_empty && !byte_empty),
		.byte_data   (byte_out.data),
		.byte_last   (byte_out.last),
		.byte_pop    (byte_pop),
		.eth_txd     (eth_txd),
		.eth_txen    (eth_txen),
		.eth_txer    (eth_txer),
		.frame_end   (frame_end)
	);

	// Each consumed byte frees one buffer slot
	assign credit_return = byte_pop;
	assign done          = frame_end;

endmodule

// File: rtl/frame_dispatcher.sv
// Frame dispatcher steering input frames to lanes with per-lane credit tracking
`timescale 1ns/1ps

module frame_dispatcher
(
	input  logic                          clk,
	input  logic                          sresetn,
	input  logic [7:0]                    s_tdata,
	input  logic                          s_tlast,
	input  logic [mac_pkg::PORT_BITS-1:0] s_tdest,
	input  logic                          s_tvalid,
	output logic                          s_tready,
	output logic [7:0]                    lane_tdata,
	output logic                          lane_tlast,
	output logic [mac_pkg::NUM_PORTS-1:0] lane_push,
	input  logic [mac_pkg::NUM_PORTS-1:0] credit_return
);

	typedef logic [mac_pkg::CREDIT_BITS-1:0] credit_t;

	// Free buffer bytes per lane
	credit_t                       credit [mac_pkg::NUM_PORTS];

	// Destination latched on the first byte of a frame
	logic                          in_frame;
	logic [mac_pkg::PORT_BITS-1:0] dest_q;
	logic [mac_pkg::PORT_BITS-1:0] sel;

	// Held low for one cycle after reset releases
	logic                          ready_en;
	logic                          accept;

	assign sel      = in_frame ? dest_q : s_tdest;
	assign s_tready = ready_en && (credit[sel] != '0);
	assign accept   = s_tvalid && s_tready;

	// Data goes to all lanes, only the selected one pushes
	assign lane_tdata = s_tdata;
	assign lane_tlast = s_tlast;

	always_comb
	begin
		for (int i = 0; i < mac_pkg::NUM_PORTS; i++)
			lane_push[i] = accept && (int'(sel) == i);
	end

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			ready_en <= 1'b0;
			in_frame <= 1'b0;
			dest_q   <= '0;
			for (int i = 0; i < mac_pkg::NUM_PORTS; i++)
				credit[i] <= credit_t'(mac_pkg::FIFO_DEPTH);
		end
		else
		begin
			ready_en <= 1'b1;
			if (accept)
			begin
				in_frame <= !s_tlast;
				dest_q   <= sel;
			end
			// Push and return in the same cycle cancel out
			for (int i = 0; i < mac_pkg::NUM_PORTS; i++)
				case ({lane_push[i], credit_return[i]})
					2'b10: credit[i] <= credit[i] - 1'b1;
					2'b01: credit[i] <= credit[i] + 1'b1;
					default: ;
				endcase
		end
	end

endmodule

// File: rtl/tx_stats.sv
// Per-port frame and byte counters fed by lane completion reports
`timescale 1ns/1ps

module tx_stats
(
	input  logic                                                 clk,
	input  logic                                                 sresetn,
	input  logic [mac_pkg::NUM_PORTS-1:0]                        done,
	input  logic [mac_pkg::NUM_PORTS-1:0][mac_pkg::LEN_BITS-1:0] done_len,
	output logic [mac_pkg::NUM_PORTS-1:0][mac_pkg::COUNT_BITS-1:0] frame_count,
	output logic [mac_pkg::NUM_PORTS-1:0][mac_pkg::COUNT_BITS-1:0] byte_count
);

	typedef logic [mac_pkg::COUNT_BITS-1:0] count_t;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			frame_count <= '0;
			byte_count  <= '0;
		end
		else
		begin
			// Both counters wrap silently
			for (int i = 0; i < mac_pkg::NUM_PORTS; i++)
				if (done[i])
				begin
					frame_count[i] <= frame_count[i] + 1'b1;
					// Unpadded length, pad and FCS not counted
					byte_count[i]  <= byte_count[i] + count_t'(done_len[i]);
				end
		end
	end

endmodule

// File: rtl/gmii_tx_subsystem.sv
// Top level with dispatcher, generated transmit lanes and statistics block
`timescale 1ns/1ps

module gmii_tx_subsystem
(
	input  logic                                                   clk,
	input  logic                                                   sresetn,
	input  logic [7:0]                                             s_tdata,
	input  logic                                                   s_tlast,
	input  logic [mac_pkg::PORT_BITS-1:0]                          s_tdest,
	input  logic                                                   s_tvalid,
	output logic                                                   s_tready,
	output logic [mac_pkg::NUM_PORTS-1:0][7:0]                     eth_txd,
	output logic [mac_pkg::NUM_PORTS-1:0]                          eth_txen,
	output logic [mac_pkg::NUM_PORTS-1:0]                          eth_txer,
	output logic [mac_pkg::NUM_PORTS-1:0][mac_pkg::COUNT_BITS-1:0] frame_count,
	output logic [mac_pkg::NUM_PORTS-1:0][mac_pkg::COUNT_BITS-1:0] byte_count
);

	// Shared lane write bus
	logic [7:0]                                   lane_tdata;
	logic                                         lane_tlast;
	logic [mac_pkg::NUM_PORTS-1:0]                lane_push;
	logic [mac_pkg::NUM_PORTS-1:0]                credit_return;

	// Completion reports
	logic [mac_pkg::NUM_PORTS-1:0]                done;
	logic [mac_pkg::NUM_PORTS-1:0][mac_pkg::LEN_BITS-1:0] done_len;

	frame_dispatcher u_dispatcher (
		.clk           (clk),
		.sresetn       (sresetn),
		.s_tdata       (s_tdata),
		.s_tlast       (s_tlast),
		.s_tdest       (s_tdest),
		.s_tvalid      (s_tvalid),
		.s_tready      (s_tready),
		.lane_tdata    (lane_tdata),
		.lane_tlast    (lane_tlast),
		.lane_push     (lane_push),
		.credit_return (credit_return)
	);

	// One lane and MAC per port
	for (genvar i = 0; i < mac_pkg::NUM_PORTS; i++)
	begin : g_lane
		tx_lane u_lane (
			.clk           (clk),
			.sresetn       (sresetn),
			.push          (lane_push[i]),
			.push_data     (lane_tdata),
			.push_last     (lane_tlast),
			.credit_return (credit_return[i]),
			.eth_txd       (eth_txd[i]),
			.eth_txen      (eth_txen[i]),
			.eth_txer      (eth_txer[i]),
			.done          (done[i]),
			.done_len      (done_len[i])
		);
	end

	tx_stats u_stats (
		.clk         (clk),
		.sresetn     (sresetn),
		.done        (done),
		.done_len    (done_len),
		.frame_count (frame_count),
		.byte_count  (byte_count)
	);

endmodule

// File: verification/tb_clock_gen.sv
// Testbench clock and reset generator
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic sresetn
);

	// 20 ns period
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	// Release lines up with the stimulus drive delay
	localparam int RELEASE_DELAY = 2;

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	initial
	begin
		sresetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#RELEASE_DELAY sresetn = 1'b1;
	end

endmodule

// File: verification/gmii_tx_checker.sv
// Lane protocol checker for FIFO overflow and underflow, txer and inter-packet gap
`timescale 1ns/1ps

module gmii_tx_checker
(
	input logic clk,
	input logic sresetn,
	input logic push,
	input logic byte_pop,
	input logic byte_empty,
	input logic token_push,
	input logic token_pop,
	input logic token_empty,
	input logic eth_txen,
	input logic eth_txer
);

	// Shadow occupancy of both lane FIFOs
	int byte_level;
	int token_level;
	// Consecutive low cycles of eth_txen, saturating
	int low_run;
	// Read by the testbench at the end of the run
	int fail_count = 0;

	always @(posedge clk)
	begin
		if (!sresetn)
		begin
			byte_level  <= 0;
			token_level <= 0;
			// Idle line after reset counts as a full gap
			low_run     <= mac_pkg::IPG_CYCLES;
		end
		else
		begin
			byte_level  <= byte_level + int'(push) - int'(byte_pop);
			token_level <= token_level + int'(token_push) - int'(token_pop);
			if (eth_txen)
				low_run <= 0;
			else if (low_run < mac_pkg::IPG_CYCLES)
				low_run <= low_run + 1;
		end
	end

	// ----------------------------------------
	// FIFO bounds
	// ----------------------------------------

	byte_full_push: assert property (@(posedge clk) disable iff (!sresetn)
		push |-> byte_level < mac_pkg::FIFO_DEPTH)
	else
	begin
		$error("Push into a full byte FIFO");
		fail_count++;
	end

	token_full_push: assert property (@(posedge clk) disable iff (!sresetn)
		token_push |-> token_level < mac_pkg::FIFO_DEPTH)
	else
	begin
		$error("Push into a full token FIFO");
		fail_count++;
	end

	byte_empty_pop: assert property (@(posedge clk) disable iff (!sresetn)
		byte_pop |-> !byte_empty)
	else
	begin
		$error("Pop from an empty byte FIFO");
		fail_count++;
	end

	token_empty_pop: assert property (@(posedge clk) disable iff (!sresetn)
		token_pop |-> !token_empty)
	else
	begin
		$error("Pop from an empty token FIFO");
		fail_count++;
	end

	// ----------------------------------------
	// GMII line rules
	// ----------------------------------------

	txer_low: assert property (@(posedge clk) disable iff (!sresetn) !eth_txer)
	else
	begin
		$error("eth_txer went high");
		fail_count++;
	end

	// Sampled low_run holds the idle cycles before this rise
	ipg_kept: assert property (@(posedge clk) disable iff (!sresetn)
		$rose(eth_txen) |-> low_run >= mac_pkg::IPG_CYCLES)
	else
	begin
		$error("eth_txen rose before the inter-packet gap ended");
		fail_count++;
	end

endmodule

bind tx_lane gmii_tx_checker u_checker (
	.clk         (clk),
	.sresetn     (sresetn),
	.push        (push),
	.byte_pop    (byte_pop),
	.byte_empty  (byte_empty),
	.token_push  (token_push),
	.token_pop   (token_pop),
	.token_empty (token_empty),
	.eth_txen    (eth_txen),
	.eth_txer    (eth_txer)
);

// File: verification/gmii_tx_tb.sv
// Testbench with stimulus, GMII capture, reference frame builder, comparison and watchdog
`timescale 1ns/1ps

module gmii_tx_tb;

	localparam int NP = mac_pkg::NUM_PORTS;
	localparam int DRIVE_DELAY = 2;
	localparam int SHORT_FRAMES = 12;
	localparam int LONG_FRAMES = 12;
	// Back-to-back burst long enough to run a lane out of credits
	localparam int BURST_FRAMES = 8;
	localparam int BURST_PORT = 2;
	localparam int BURST_LEN = 200;
	localparam int NUM_FRAMES = SHORT_FRAMES + LONG_FRAMES + BURST_FRAMES;
	localparam logic [31:0] FCS_POLY = 32'hEDB8_8320;

	typedef logic [7:0] byte_q_t [$];

	logic                                 clk;
	logic                                 sresetn;
	logic [7:0]                           s_tdata;
	logic                                 s_tlast;
	logic [mac_pkg::PORT_BITS-1:0]        s_tdest;
	logic                                 s_tvalid;
	logic                                 s_tready;
	logic [NP-1:0][7:0]                   eth_txd;
	logic [NP-1:0]                        eth_txen;
	logic [NP-1:0]                        eth_txer;
	logic [NP-1:0][mac_pkg::COUNT_BITS-1:0] frame_count;
	logic [NP-1:0][mac_pkg::COUNT_BITS-1:0] byte_count;

	int seed = 32'hed51_7092;

	// Frame ports and lengths are drawn before reset so the watchdog knows the run length
	int   plan_port [NUM_FRAMES];
	int   plan_len [NUM_FRAMES];
	int   total_cycles = 0;
	logic plan_ready = 1'b0;

	// Expected wire frames per port are flattened alongside a length queue
	logic [7:0] exp_bytes [NP][$];
	int         exp_lens [NP][$];
	int         exp_frames [NP];
	int         exp_byte_sum [NP];

	// Captured wire frames and the idle gap before each
	logic [7:0] got_bytes [NP][$];
	int         got_lens [NP][$];
	int         got_gaps [NP][$];

	logic [NP-1:0] checker_failed;

	// One error count per checking process
	int reset_errors = 0;
	int frame_errors = 0;
	int final_errors = 0;
	int frames_checked = 0;

	tb_clock_gen u_clock_gen (
		.clk     (clk),
		.sresetn (sresetn)
	);

	gmii_tx_subsystem u_gmii_tx_subsystem (
		.clk         (clk),
		.sresetn     (sresetn),
		.s_tdata     (s_tdata),
		.s_tlast     (s_tlast),
		.s_tdest     (s_tdest),
		.s_tvalid    (s_tvalid),
		.s_tready    (s_tready),
		.eth_txd     (eth_txd),
		.eth_txen    (eth_txen),
		.eth_txer    (eth_txer),
		.frame_count (frame_count),
		.byte_count  (byte_count)
	);

	// ----------------------------------------
	// Reference model
	// ----------------------------------------

	// Bitwise CRC-32 over a whole byte string with a final inversion
	function automatic logic [31:0] crc32_of(input byte_q_t data);
		logic [31:0] crc;
		crc = 32'hFFFF_FFFF;
		foreach (data[i])
		begin
			crc = crc ^ {24'h0, data[i]};
			for (int b = 0; b < 8; b++)
				crc = crc[0] ? ((crc >> 1) ^ FCS_POLY) : (crc >> 1);
		end
		return ~crc;
	endfunction

	// Preamble, SFD, padded payload, FCS low byte first
	function automatic byte_q_t expected_frame(input byte_q_t payload);
		byte_q_t     body;
		byte_q_t     frame;
		logic [31:0] fcs;
		body = payload;
		while (body.size() < mac_pkg::MIN_PAYLOAD)
			body.push_back(8'h00);
		fcs = crc32_of(body);
		repeat (mac_pkg::PREAMBLE_BYTES)
			frame.push_back(8'h55);
		frame.push_back(8'hD5);
		foreach (body[i])
			frame.push_back(body[i]);
		for (int k = 0; k < 4; k++)
			frame.push_back(fcs[8*k +: 8]);
		return frame;
	endfunction

	function automatic int wire_cycles(input int len);
		return 8 + ((len > mac_pkg::MIN_PAYLOAD) ? len : mac_pkg::MIN_PAYLOAD) + 4;
	endfunction

	function automatic logic all_drained();
		logic drained;
		drained = (eth_txen == '0);
		for (int p = 0; p < NP; p++)
			if (exp_lens[p].size() != 0 || got_lens[p].size() != 0)
				drained = 1'b0;
		return drained;
	endfunction

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	// Queues the expected frame, then drives the payload byte by byte
	task automatic send_frame(input int port, input int len, input logic bubbles);
		byte_q_t payload;
		byte_q_t frame;
		logic    accepted;
		for (int i = 0; i < len; i++)
			payload.push_back(8'($random(seed)));
		frame = expected_frame(payload);
		foreach (frame[i])
			exp_bytes[port].push_back(frame[i]);
		exp_lens[port].push_back(frame.size());
		exp_frames[port]++;
		exp_byte_sum[port] += len;
		for (int i = 0; i < len; i++)
		begin
			// Random idle cycle between transfers
			if (bubbles && ($unsigned($random(seed)) % 4) == 0)
			begin
				s_tvalid = 1'b0;
				@(posedge clk);
				#DRIVE_DELAY;
			end
			s_tvalid = 1'b1;
			s_tdata  = payload[i];
			s_tlast  = (i == len - 1);
			s_tdest  = port[mac_pkg::PORT_BITS-1:0];
			accepted = 1'b0;
			// s_tready is settled by the falling edge
			while (!accepted)
			begin
				@(negedge clk);
				accepted = s_tready;
				@(posedge clk);
				#DRIVE_DELAY;
			end
		end
		s_tvalid = 1'b0;
		s_tlast  = 1'b0;
	endtask

	initial
	begin
		s_tdata  = 8'h00;
		s_tlast  = 1'b0;
		s_tdest  = '0;
		s_tvalid = 1'b0;
		for (int p = 0; p < NP; p++)
		begin
			exp_frames[p]   = 0;
			exp_byte_sum[p] = 0;
		end
		for (int n = 0; n < NUM_FRAMES; n++)
		begin
			if (n < SHORT_FRAMES)
			begin
				plan_port[n] = $unsigned($random(seed)) % NP;
				plan_len[n]  = 1 + $unsigned($random(seed)) % 59;
			end
			else if (n < SHORT_FRAMES + LONG_FRAMES)
			begin
				plan_port[n] = $unsigned($random(seed)) % NP;
				plan_len[n]  = 60 + $unsigned($random(seed)) % 141;
			end
			else
			begin
				plan_port[n] = BURST_PORT;
				plan_len[n]  = BURST_LEN;
			end
			total_cycles += wire_cycles(plan_len[n]);
		end
		plan_ready = 1'b1;

		wait (sresetn === 1'b1);
		@(posedge clk);
		#DRIVE_DELAY;
		// Short and long frames with random valid gaps, then a gapless burst
		for (int n = 0; n < NUM_FRAMES; n++)
			send_frame(plan_port[n], plan_len[n], n < SHORT_FRAMES + LONG_FRAMES);

		while (!all_drained())
			@(posedge clk);
		// Counters follow the done pulse by one cycle
		repeat (2) @(posedge clk);
		@(negedge clk);
		for (int p = 0; p < NP; p++)
		begin
			assert (frame_count[p] == exp_frames[p][mac_pkg::COUNT_BITS-1:0])
			else
			begin
				$display("FAIL frame_count[%0d]: got %h expected %h",
					p, frame_count[p], exp_frames[p][mac_pkg::COUNT_BITS-1:0]);
				final_errors++;
			end
			assert (byte_count[p] == exp_byte_sum[p][mac_pkg::COUNT_BITS-1:0])
			else
			begin
				$display("FAIL byte_count[%0d]: got %h expected %h",
					p, byte_count[p], exp_byte_sum[p][mac_pkg::COUNT_BITS-1:0]);
				final_errors++;
			end
		end
		assert (checker_failed == '0)
		else
		begin
			$display("Bound lane checker saw assertion failures on lanes %b", checker_failed);
			final_errors++;
		end

		$display("Frames checked %0d, errors: reset %0d, frame %0d, final %0d",
			frames_checked, reset_errors, frame_errors, final_errors);
		if (reset_errors + frame_errors + final_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// ----------------------------------------
	// Reset state
	// ----------------------------------------

	task automatic check_reset_outputs();
		assert (eth_txen == '0 && eth_txer == '0 && s_tready == 1'b0)
		else
		begin
			$display("FAIL reset eth_txen %h eth_txer %h s_tready %h",
				eth_txen, eth_txer, s_tready);
			reset_errors++;
		end
		assert (frame_count == '0 && byte_count == '0)
		else
		begin
			$display("FAIL reset frame_count %h byte_count %h", frame_count, byte_count);
			reset_errors++;
		end
	endtask

	// Every cycle in reset after the first edge plus the first one after release
	initial
	begin
		@(posedge clk);
		@(negedge clk);
		while (!sresetn)
		begin
			check_reset_outputs();
			@(negedge clk);
		end
		check_reset_outputs();
	end

	// ----------------------------------------
	// Capture and compare
	// ----------------------------------------

	for (genvar p = 0; p < NP; p++)
	begin : g_capture
		logic [7:0] cur [$];
		int         idle = mac_pkg::IPG_CYCLES;

		always @(negedge clk)
		begin
			if (eth_txen[p])
			begin
				if (cur.size() == 0)
					got_gaps[p].push_back(idle);
				cur.push_back(eth_txd[p]);
				idle = 0;
			end
			else
			begin
				// Falling eth_txen closes the frame
				if (cur.size() != 0)
				begin
					foreach (cur[i])
						got_bytes[p].push_back(cur[i]);
					got_lens[p].push_back(cur.size());
					cur.delete();
				end
				idle++;
			end
		end

		assign checker_failed[p] =
			(u_gmii_tx_subsystem.g_lane[p].u_lane.u_checker.fail_count != 0);
	end

	task automatic compare_frame(input int p);
		int         got_len;
		int         got_gap;
		int         exp_len;
		logic [7:0] got;
		logic [7:0] want;
		got_len = got_lens[p].pop_front();
		got_gap = got_gaps[p].pop_front();
		frames_checked++;
		assert (got_gap >= mac_pkg::IPG_CYCLES)
		else
		begin
			$display("Port %0d started a frame after only %0d idle cycles", p, got_gap);
			frame_errors++;
		end
		assert (exp_lens[p].size() != 0)
		else
		begin
			$display("Port %0d sent a frame that was routed to another port", p);
			frame_errors++;
		end
		if (exp_lens[p].size() == 0)
		begin
			repeat (got_len)
				void'(got_bytes[p].pop_front());
		end
		else
		begin
			exp_len = exp_lens[p].pop_front();
			assert (got_len == exp_len)
			else
			begin
				$display("FAIL eth_txen[%0d] frame length: got %h expected %h",
					p, got_len, exp_len);
				frame_errors++;
			end
			for (int i = 0; i < exp_len; i++)
			begin
				want = exp_bytes[p].pop_front();
				if (i < got_len)
				begin
					got = got_bytes[p].pop_front();
					assert (got == want)
					else
					begin
						$display("FAIL eth_txd[%0d] byte %0d: got %h expected %h",
							p, i, got, want);
						frame_errors++;
					end
				end
			end
			for (int i = exp_len; i < got_len; i++)
				void'(got_bytes[p].pop_front());
		end
	endtask

	always @(negedge clk)
	begin
		for (int p = 0; p < NP; p++)
			if (got_lens[p].size() != 0)
				compare_frame(p);
	end

	// ----------------------------------------
	// Watchdog
	// ----------------------------------------

	initial
	begin
		wait (plan_ready);
		repeat (total_cycles * 4 + 2000) @(posedge clk);
		$display("Timeout after %0d cycles with frames still outstanding",
			total_cycles * 4 + 2000);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: gmii_tx_subsystem.f
rtl/mac_pkg.sv
rtl/sync_fifo.sv
rtl/gmii_tx_mac.sv
rtl/tx_lane.sv
rtl/frame_dispatcher.sv
rtl/tx_stats.sv
rtl/gmii_tx_subsystem.sv
verification/tb_clock_gen.sv
verification/gmii_tx_checker.sv
verification/gmii_tx_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := gmii_tx_tb
FILELIST  := gmii_tx_subsystem.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := All checks passed
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard rtl/*.sv verification/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
